/* fetchControl.sv */
`timescale 1ns/1ps
`default_nettype none
`include "issueUnit_defines.svh"

module fetchControl (
  input  wire                     clockIn,
  input  wire                     resetIn,
  input  wire                     instrInValid,
  input  wire issuePkg::rvInstr_u instrIn,
  input  wire                     robFull,
  input  wire                     rsFull,
  input  wire                     lsbFull,
  output logic                    instrOutValid,
  stageIf.fetch                   stage
);
  import issuePkg::*;

  typedef enum logic {
    READY,
    JUMP_WAIT
  } fetchState_e;

  fetchState_e state;
  logic        memOp;
  logic        aluOp;
  logic        isJal;
  logic        blocked;
  logic        accept;

  assign memOp   = instrIn.r.opcode == LOAD || instrIn.r.opcode == STORE;
  assign aluOp   = instrIn.r.opcode == OP || instrIn.r.opcode == OPIMM;
  assign isJal   = instrIn.r.opcode == JAL;
  assign blocked = robFull || (memOp && lsbFull) || (aluOp && rsFull);

  assign instrOutValid = state == READY;
  assign accept        = instrInValid && instrOutValid && !blocked;
  assign stage.advance = accept && !isJal; // JAL keeps the PC until decode

  always_ff @(posedge clockIn) begin
    if (resetIn) begin
      state            <= READY;
      stage.instrValid <= 1'b0;
    end else begin
      stage.instrValid <= accept;
      case (state)
        READY: begin
          if (accept && isJal) begin
            state <= JUMP_WAIT;
          end
        end
        JUMP_WAIT: begin
          if (stage.jumpTaken) begin
            state <= READY; // Target loaded at this edge
          end
        end
        default: state <= READY;
      endcase
    end
  end

  // Decode register
  always_ff @(posedge clockIn) begin
    if (accept) begin
      stage.instr     <= instrIn;
      stage.instrAddr <= stage.pc;
    end
  end

endmodule

`default_nettype wire

/* instructionUnit.sv */
`timescale 1ns/1ps
`default_nettype none
`include "issueUnit_defines.svh"

module instructionUnit (
  input  wire                        clockIn,
  input  wire                        resetIn,
  input  wire                        instrInValid,
  input  wire [`XLEN-1:0]            instrIn,
  output logic                       instrOutValid,
  output logic [`XLEN-1:0]           instrAddrOut,
  input  wire                        robFull,
  input  wire [`ROB_WIDTH-1:0]       robNext,
  output logic                       robAddValid,
  output issuePkg::robType_e         robAddType,
  output logic                       robAddReady,
  output logic [`XLEN-1:0]           robAddValue,
  output logic [`REG_ADDR_WIDTH-1:0] robAddDest,
  input  wire                        rsFull,
  input  wire                        rsUpdate,
  input  wire [`ROB_WIDTH-1:0]       rsRobIndex,
  input  wire [`XLEN-1:0]            rsUpdateVal,
  output logic                       rsAddValid,
  output issuePkg::rsOp_e            rsAddOp,
  output logic [`ROB_WIDTH-1:0]      rsAddRobIndex,
  output logic [`XLEN-1:0]           rsAddVal1,
  output logic                       rsAddHasDep1,
  output logic [`ROB_WIDTH-1:0]      rsAddConstrt1,
  output logic [`XLEN-1:0]           rsAddVal2,
  output logic                       rsAddHasDep2,
  output logic [`ROB_WIDTH-1:0]      rsAddConstrt2,
  input  wire                        lsbFull,
  input  wire                        lsbUpdate,
  input  wire [`ROB_WIDTH-1:0]       lsbRobIndex,
  input  wire [`XLEN-1:0]            lsbUpdateVal,
  output logic                       lsbAddValid,
  output logic                       lsbAddReadWrite,
  output logic [`ROB_WIDTH-1:0]      lsbAddRobId,
  output logic                       lsbAddHasDep,
  output logic [`XLEN-1:0]           lsbAddBase,
  output logic [`ROB_WIDTH-1:0]      lsbAddConstrtId,
  output logic [`XLEN-1:0]           lsbAddOffset,
  output logic [`REG_ADDR_WIDTH-1:0] lsbAddTarget,
  output issuePkg::lsbOp_e           lsbAddOp,
  output logic [`REG_ADDR_WIDTH-1:0] rs1Addr,
  output logic [`REG_ADDR_WIDTH-1:0] rs2Addr,
  input  wire                        rs1Dirty,
  input  wire [`ROB_WIDTH-1:0]       rs1Dependency,
  input  wire [`XLEN-1:0]            rs1Value,
  input  wire                        rs2Dirty,
  input  wire [`ROB_WIDTH-1:0]       rs2Dependency,
  input  wire [`XLEN-1:0]            rs2Value,
  output logic                       rfUpdateValid,
  output logic [`REG_ADDR_WIDTH-1:0] rfUpdateDest,
  output logic [`ROB_WIDTH-1:0]      rfUpdateIndex
);

  stageIf   stage ();
  operandIf ops ();

  fetchControl i_fetchControl (
    .stage (stage),
    .*
  );

  programCounter i_programCounter (
    .clockIn (clockIn),
    .resetIn (resetIn),
    .stage   (stage),
    .pc      (instrAddrOut) // Fetch address to the cache
  );

  operandResolver i_operandResolver (
    .ops (ops),
    .*
  );

  issueDecoder i_issueDecoder (
    .stage (stage),
    .ops   (ops),
    .*
  );

endmodule

`default_nettype wire

/* instructionUnitTb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "issueUnit_defines.svh"

module instructionUnitTb;
  import issuePkg::*;

  localparam int numCycles  = 3000;
  localparam int drainLimit = 40;

  wire                        clockIn;
  wire                        resetIn;
  logic                       instrInValid;
  logic [`XLEN-1:0]           instrIn;
  logic                       instrOutValid;
  logic [`XLEN-1:0]           instrAddrOut;
  logic                       robFull;
  logic [`ROB_WIDTH-1:0]      robNext;
  logic                       robAddValid;
  robType_e                   robAddType;
  logic                       robAddReady;
  logic [`XLEN-1:0]           robAddValue;
  logic [`REG_ADDR_WIDTH-1:0] robAddDest;
  logic                       rsFull;
  logic                       rsUpdate;
  logic [`ROB_WIDTH-1:0]      rsRobIndex;
  logic [`XLEN-1:0]           rsUpdateVal;
  logic                       rsAddValid;
  rsOp_e                      rsAddOp;
  logic [`ROB_WIDTH-1:0]      rsAddRobIndex;
  logic [`XLEN-1:0]           rsAddVal1;
  logic                       rsAddHasDep1;
  logic [`ROB_WIDTH-1:0]      rsAddConstrt1;
  logic [`XLEN-1:0]           rsAddVal2;
  logic                       rsAddHasDep2;
  logic [`ROB_WIDTH-1:0]      rsAddConstrt2;
  logic                       lsbFull;
  logic                       lsbUpdate;
  logic [`ROB_WIDTH-1:0]      lsbRobIndex;
  logic [`XLEN-1:0]           lsbUpdateVal;
  logic                       lsbAddValid;
  logic                       lsbAddReadWrite;
  logic [`ROB_WIDTH-1:0]      lsbAddRobId;
  logic                       lsbAddHasDep;
  logic [`XLEN-1:0]           lsbAddBase;
  logic [`ROB_WIDTH-1:0]      lsbAddConstrtId;
  logic [`XLEN-1:0]           lsbAddOffset;
  logic [`REG_ADDR_WIDTH-1:0] lsbAddTarget;
  lsbOp_e                     lsbAddOp;
  logic [`REG_ADDR_WIDTH-1:0] rs1Addr;
  logic [`REG_ADDR_WIDTH-1:0] rs2Addr;
  logic                       rs1Dirty;
  logic [`ROB_WIDTH-1:0]      rs1Dependency;
  logic [`XLEN-1:0]           rs1Value;
  logic                       rs2Dirty;
  logic [`ROB_WIDTH-1:0]      rs2Dependency;
  logic [`XLEN-1:0]           rs2Value;
  logic                       rfUpdateValid;
  logic [`REG_ADDR_WIDTH-1:0] rfUpdateDest;
  logic [`ROB_WIDTH-1:0]      rfUpdateIndex;

  // Register file contents as seen by the front end
  logic [`XLEN-1:0]      rfValue [32];
  logic                  rfDirty [32];
  logic [`ROB_WIDTH-1:0] rfTag [32];

  logic [`XLEN-1:0] expPc;
  logic [`XLEN-1:0] decWord;
  logic [`XLEN-1:0] decAddr;
  logic [`XLEN-1:0] acceptWord;
  logic             expWait;
  logic             decValid;   // Word in decode, issues at next edge
  logic             decLoaded;
  logic             acceptNow;  // Predicted for the coming edge

  logic                       eRob;
  logic                       eRf;
  logic                       eRs;
  logic                       eLsb;
  logic                       eReady;
  logic                       eHas1;
  logic                       eHas2;
  logic                       eRw;
  robType_e                   eType;
  rsOp_e                      eOp;
  lsbOp_e                     eSize;
  logic [`XLEN-1:0]           eValue;
  logic [`XLEN-1:0]           eVal1;
  logic [`XLEN-1:0]           eVal2;
  logic [`XLEN-1:0]           eOffset;
  logic [6:0]                 eOpc;
  logic [`REG_ADDR_WIDTH-1:0] eDest;
  logic [`REG_ADDR_WIDTH-1:0] eTarget;
  logic [`ROB_WIDTH-1:0]      eIndex;
  logic [`ROB_WIDTH-1:0]      eTag1;
  logic [`ROB_WIDTH-1:0]      eTag2;

  int errors;
  int checks;
  int accepts;
  int cycle;
  int waitCount;

  tbClock i_clock (
    .clock (clockIn),
    .reset (resetIn)
  );

  instructionUnit i_dut (.*);

  task automatic expectEqual(input string name, input logic [`XLEN-1:0] actual,
                             input logic [`XLEN-1:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
    end
  endtask

  function automatic logic [`XLEN-1:0] randomWord();
    logic [`XLEN-1:0] w;
    logic [2:0]       f3;
    w  = $urandom;
    f3 = w[14:12];
    case ($urandom_range(6))
      0: w[6:0] = LUI;
      1: w[6:0] = AUIPC;
      2: w[6:0] = JAL;
      3: begin
        w[6:0]   = LOAD;
        w[14:12] = (f3 == 3'd3 || f3 > 3'd5) ? 3'd2 : f3; // LB LH LW LBU LHU
      end
      4: begin
        w[6:0]   = STORE;
        w[14:12] = f3 % 3'd3;
      end
      5: begin
        w[6:0]   = OP;
        w[31:25] = (w[30] && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00;
      end
      default: begin
        w[6:0] = OPIMM;
        if (f3 == 3'd1 || f3 == 3'd5) begin
          w[31:25] = (f3 == 3'd5 && w[30]) ? 7'h20 : 7'h00; // Legal shift encodings
        end
      end
    endcase
    if ($urandom_range(7) == 0) begin
      w[11:7] = '0; // Destination x0
    end
    return w;
  endfunction

  function automatic rsOp_e aluOpFor(input logic [`XLEN-1:0] w);
    case (w[14:12])
      3'd0:    return (w[6:0] == OP && w[30]) ? SUB : ADD;
      3'd1:    return SLL;
      3'd2:    return SLT;
      3'd3:    return SLTU;
      3'd4:    return XOR;
      3'd5:    return w[30] ? SRA : SRL;
      3'd6:    return OR;
      default: return AND;
    endcase
  endfunction

  function automatic lsbOp_e sizeFor(input logic [2:0] f3);
    case (f3)
      3'd0:    return BYTE;
      3'd1:    return HALF;
      3'd4:    return BYTEU;
      3'd5:    return HALFU;
      default: return WORD;
    endcase
  endfunction

  function automatic logic [`XLEN-1:0] jumpOffset(input logic [`XLEN-1:0] w);
    return {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
  endfunction

  // Broadcast tag that often hits a source of the word in decode
  function automatic logic [`ROB_WIDTH-1:0] pickTag(input logic [`XLEN-1:0] w);
    case ($urandom_range(2))
      0:       return rfTag[w[19:15]];
      1:       return rfTag[w[24:20]];
      default: return `ROB_WIDTH'($urandom);
    endcase
  endfunction

  function automatic logic isIdle();
    return !instrInValid && !decValid && !expWait && !(eRob || eRf || eRs || eLsb);
  endfunction

  task automatic resolveOperand(input logic dirty, input logic [`ROB_WIDTH-1:0] tag,
                                input logic [`XLEN-1:0] clean,
                                output logic [`XLEN-1:0] val, output logic hasDep);
    hasDep = 1'b0;
    if (!dirty) begin
      val = clean;
    end else if (rsUpdate && rsRobIndex == tag) begin
      val = rsUpdateVal;
    end else if (lsbUpdate && lsbRobIndex == tag) begin
      val = lsbUpdateVal;
    end else begin
      val    = '0;
      hasDep = 1'b1;
    end
  endtask

  task automatic predictIssue();
    logic [`XLEN-1:0] w;
    logic [`XLEN-1:0] iImm;
    logic [`XLEN-1:0] uImm;
    logic             rdNonZero;
    eRob = 1'b0;
    eRf  = 1'b0;
    eRs  = 1'b0;
    eLsb = 1'b0;
    if (!decValid) return;
    w         = decWord;
    iImm      = {{20{w[31]}}, w[31:20]};
    uImm      = {w[31:12], 12'b0};
    rdNonZero = w[11:7] != '0;
    eOpc      = w[6:0];
    eDest     = w[11:7];
    eIndex    = robNext;
    eTag1     = rs1Dependency;
    eTag2     = rs2Dependency;
    eType     = REGWRITE;
    eReady    = 1'b0;
    resolveOperand(rs1Dirty, rs1Dependency, rs1Value, eVal1, eHas1);
    resolveOperand(rs2Dirty, rs2Dependency, rs2Value, eVal2, eHas2);
    case (w[6:0])
      LUI, AUIPC, JAL: begin
        eRob   = rdNonZero;
        eRf    = rdNonZero;
        eReady = 1'b1;
        if (w[6:0] == LUI) eValue = uImm;
        else if (w[6:0] == AUIPC) eValue = decAddr + uImm;
        else eValue = decAddr + `INSTR_BYTES; // Link address
      end
      OP, OPIMM: begin
        eRob = 1'b1;
        eRf  = rdNonZero;
        eRs  = 1'b1;
        eOp  = aluOpFor(w);
        if (w[6:0] == OPIMM) begin
          eHas2 = 1'b0;
          if (w[14:12] == 3'd1 || w[14:12] == 3'd5) eVal2 = {27'b0, w[24:20]};
          else if (w[14:12] == 3'd3) eVal2 = {20'b0, w[31:20]}; // SLTIU
          else eVal2 = iImm;
        end
      end
      LOAD, STORE: begin
        eRob    = 1'b1;
        eRf     = w[6:0] == LOAD;
        eLsb    = 1'b1;
        eRw     = w[6:0] == LOAD;
        eType   = (w[6:0] == STORE) ? MEMWRITE : REGWRITE;
        eOffset = (w[6:0] == STORE) ? {{20{w[31]}}, w[31:25], w[11:7]} : iImm;
        eTarget = w[24:20];
        eSize   = sizeFor(w[14:12]);
      end
      default: begin
      end
    endcase
  endtask

  task automatic checkIssue();
    expectEqual("robAddValid", robAddValid, eRob);
    expectEqual("rfUpdateValid", rfUpdateValid, eRf);
    expectEqual("rsAddValid", rsAddValid, eRs);
    expectEqual("lsbAddValid", lsbAddValid, eLsb);
    if (eRob) begin
      expectEqual("robAddType", robAddType, eType);
      expectEqual("robAddReady", robAddReady, eReady);
      if (eReady) expectEqual("robAddValue", robAddValue, eValue);
      if (eOpc != STORE) expectEqual("robAddDest", robAddDest, eDest);
    end
    if (eRf) begin
      expectEqual("rfUpdateDest", rfUpdateDest, eDest);
      expectEqual("rfUpdateIndex", rfUpdateIndex, eIndex);
    end
    if (eRs) begin
      expectEqual("rsAddOp", rsAddOp, eOp);
      expectEqual("rsAddRobIndex", rsAddRobIndex, eIndex);
      expectEqual("rsAddVal1", rsAddVal1, eVal1);
      expectEqual("rsAddHasDep1", rsAddHasDep1, eHas1);
      if (eHas1) expectEqual("rsAddConstrt1", rsAddConstrt1, eTag1);
      expectEqual("rsAddVal2", rsAddVal2, eVal2);
      expectEqual("rsAddHasDep2", rsAddHasDep2, eHas2);
      if (eHas2) expectEqual("rsAddConstrt2", rsAddConstrt2, eTag2);
    end
    if (eLsb) begin
      expectEqual("lsbAddReadWrite", lsbAddReadWrite, eRw);
      expectEqual("lsbAddRobId", lsbAddRobId, eIndex);
      expectEqual("lsbAddHasDep", lsbAddHasDep, eHas1);
      expectEqual("lsbAddBase", lsbAddBase, eVal1);
      if (eHas1) expectEqual("lsbAddConstrtId", lsbAddConstrtId, eTag1);
      expectEqual("lsbAddOffset", lsbAddOffset, eOffset);
      expectEqual("lsbAddOp", lsbAddOp, eSize);
      if (!eRw) expectEqual("lsbAddTarget", lsbAddTarget, eTarget);
    end
  endtask

  // Runs at the falling edge, when all outputs are settled
  task automatic checkCycle();
    logic memOp;
    logic aluOp;
    expectEqual("instrOutValid", instrOutValid, !expWait);
    expectEqual("instrAddrOut", instrAddrOut, expPc);
    if (decLoaded) begin
      expectEqual("rs1Addr", rs1Addr, decWord[19:15]);
      expectEqual("rs2Addr", rs2Addr, decWord[24:20]);
    end
    checkIssue();
    predictIssue();
    memOp      = instrIn[6:0] == LOAD || instrIn[6:0] == STORE;
    aluOp      = instrIn[6:0] == OP || instrIn[6:0] == OPIMM;
    acceptWord = instrIn;
    acceptNow  = instrInValid && !expWait && !robFull && !(memOp && lsbFull) &&
                 !(aluOp && rsFull);
  endtask

  task automatic advanceModel();
    if (decValid && decWord[6:0] == JAL) begin
      expPc   = decAddr + jumpOffset(decWord); // Redirect lands with the issue
      expWait = 1'b0;
    end
    decValid = acceptNow;
    if (acceptNow) begin
      accepts++;
      decWord   = acceptWord;
      decAddr   = expPc;
      decLoaded = 1'b1;
      if (acceptWord[6:0] == JAL) expWait = 1'b1;
      else expPc = expPc + `INSTR_BYTES;
    end
  endtask

  task automatic driveInputs(input logic stimOn);
    int idx;
    idx          = $urandom_range(31);
    rfValue[idx] = $urandom;
    rfDirty[idx] = $urandom_range(1);
    rfTag[idx]   = `ROB_WIDTH'($urandom);
    if (!(instrInValid && !acceptNow)) begin // Refused word stays on the bus
      instrInValid <= stimOn && $urandom_range(3) != 0;
      instrIn      <= randomWord();
    end
    robFull       <= stimOn && $urandom_range(7) == 0;
    rsFull        <= stimOn && $urandom_range(5) == 0;
    lsbFull       <= stimOn && $urandom_range(5) == 0;
    robNext       <= `ROB_WIDTH'($urandom);
    rs1Dirty      <= rfDirty[decWord[19:15]];
    rs1Dependency <= rfTag[decWord[19:15]];
    rs1Value      <= rfValue[decWord[19:15]];
    rs2Dirty      <= rfDirty[decWord[24:20]];
    rs2Dependency <= rfTag[decWord[24:20]];
    rs2Value      <= rfValue[decWord[24:20]];
    rsUpdate      <= $urandom_range(1);
    rsRobIndex    <= pickTag(decWord);
    rsUpdateVal   <= $urandom;
    lsbUpdate     <= $urandom_range(1);
    lsbRobIndex   <= pickTag(decWord);
    lsbUpdateVal  <= $urandom;
  endtask

  initial begin
    instrInValid  = 1'b0;
    instrIn       = '0;
    robFull       = 1'b0;
    robNext       = '0;
    rsFull        = 1'b0;
    rsUpdate      = 1'b0;
    rsRobIndex    = '0;
    rsUpdateVal   = '0;
    lsbFull       = 1'b0;
    lsbUpdate     = 1'b0;
    lsbRobIndex   = '0;
    lsbUpdateVal  = '0;
    rs1Dirty      = 1'b0;
    rs1Dependency = '0;
    rs1Value      = '0;
    rs2Dirty      = 1'b0;
    rs2Dependency = '0;
    rs2Value      = '0;
    errors        = 0;
    checks        = 0;
    accepts       = 0;
    expPc         = `RESET_PC;
    expWait       = 1'b0;
    decValid      = 1'b0;
    decLoaded     = 1'b0;
    decWord       = '0;
    acceptNow     = 1'b0;
    eRob          = 1'b0;
    eRf           = 1'b0;
    eRs           = 1'b0;
    eLsb          = 1'b0;
    void'($urandom(32'h1b90_c71d));
    for (int r = 0; r < 32; r++) begin
      rfValue[r] = $urandom;
      rfDirty[r] = $urandom_range(1);
      rfTag[r]   = `ROB_WIDTH'($urandom);
    end

    waitCount = 0;
    @(negedge clockIn);
    while (resetIn !== 1'b0 && waitCount < 20) begin
      @(negedge clockIn);
      waitCount++;
    end

    if (resetIn !== 1'b0) begin
      errors++;
      $display("Timeout: reset was never released");
    end else begin
      cycle = 0;
      while ((cycle < numCycles || !isIdle()) && cycle < numCycles + drainLimit) begin
        checkCycle();
        @(posedge clockIn);
        advanceModel();
        driveInputs(cycle < numCycles - 1);
        @(negedge clockIn);
        cycle++;
      end
      checkCycle();
      if (!isIdle()) begin
        errors++;
        $display("Timeout: the front end did not drain after the last word");
      end
    end

    $display("Summary: %0d checks, %0d errors, %0d words accepted", checks, errors, accepts);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* issueDecoder.sv */
`timescale 1ns/1ps
`default_nettype none
`include "issueUnit_defines.svh"

module issueDecoder (
  input  wire                        clockIn,
  input  wire                        resetIn,
  input  wire [`ROB_WIDTH-1:0]       robNext,
  stageIf.decode                     stage,
  operandIf.decoder                  ops,
  output logic                       robAddValid,
  output issuePkg::robType_e         robAddType,
  output logic                       robAddReady,
  output logic [`XLEN-1:0]           robAddValue,
  output logic [`REG_ADDR_WIDTH-1:0] robAddDest,
  output logic                       rfUpdateValid,
  output logic [`REG_ADDR_WIDTH-1:0] rfUpdateDest,
  output logic [`ROB_WIDTH-1:0]      rfUpdateIndex,
  output logic                       rsAddValid,
  output issuePkg::rsOp_e            rsAddOp,
  output logic [`ROB_WIDTH-1:0]      rsAddRobIndex,
  output logic [`XLEN-1:0]           rsAddVal1,
  output logic                       rsAddHasDep1,
  output logic [`ROB_WIDTH-1:0]      rsAddConstrt1,
  output logic [`XLEN-1:0]           rsAddVal2,
  output logic                       rsAddHasDep2,
  output logic [`ROB_WIDTH-1:0]      rsAddConstrt2,
  output logic                       lsbAddValid,
  output logic                       lsbAddReadWrite,
  output logic [`ROB_WIDTH-1:0]      lsbAddRobId,
  output logic                       lsbAddHasDep,
  output logic [`XLEN-1:0]           lsbAddBase,
  output logic [`ROB_WIDTH-1:0]      lsbAddConstrtId,
  output logic [`XLEN-1:0]           lsbAddOffset,
  output logic [`REG_ADDR_WIDTH-1:0] lsbAddTarget,
  output issuePkg::lsbOp_e           lsbAddOp,
  output logic [`REG_ADDR_WIDTH-1:0] rs1Addr,
  output logic [`REG_ADDR_WIDTH-1:0] rs2Addr
);
  import issuePkg::*;

  rvInstr_u         instr;
  logic             rdNonZero;
  logic             isStore;
  logic [`XLEN-1:0] iImm;
  logic [`XLEN-1:0] uImm;
  logic [`XLEN-1:0] sImm;
  logic [`XLEN-1:0] jImm;
  logic             robValidNext;
  logic             rfValidNext;
  logic             rsValidNext;
  logic             lsbValidNext;
  logic             robReadyNext;
  logic [`XLEN-1:0] robValueNext;
  rsOp_e            rsOpNext;
  logic [`XLEN-1:0] val2Next;
  logic             hasDep2Next;

  function automatic rsOp_e aluOp(input logic [2:0] funct3, input logic subSel,
                                  input logic sraSel);
    case (funct3)
      3'b000:  return subSel ? SUB : ADD;
      3'b001:  return SLL;
      3'b010:  return SLT;
      3'b011:  return SLTU;
      3'b100:  return XOR;
      3'b101:  return sraSel ? SRA : SRL;
      3'b110:  return OR;
      default: return AND;
    endcase
  endfunction

  function automatic lsbOp_e sizeOp(input logic [2:0] funct3);
    case (funct3)
      3'b000:  return BYTE;
      3'b001:  return HALF;
      3'b100:  return BYTEU;
      3'b101:  return HALFU;
      default: return WORD;
    endcase
  endfunction

  assign instr     = stage.instr;
  assign rdNonZero = instr.r.rd != '0;
  assign isStore   = instr.s.opcode == STORE;
  assign rs1Addr   = instr.r.rs1; // Register file read in decode
  assign rs2Addr   = instr.r.rs2;

  assign iImm = {{(`XLEN-12){instr.i.imm[11]}}, instr.i.imm};
  assign uImm = {instr.u.imm, 12'b0};
  assign sImm = {{(`XLEN-12){instr.s.immHi[6]}}, instr.s.immHi, instr.s.immLo};
  assign jImm = {{(`XLEN-20){instr.j.imm20}}, instr.j.imm19to12, instr.j.imm11,
                 instr.j.imm10to1, 1'b0};

  assign stage.jumpTaken  = stage.instrValid && instr.j.opcode == JAL;
  assign stage.jumpTarget = stage.instrAddr + jImm;

  always_comb begin
    robValidNext = 1'b0;
    rfValidNext  = 1'b0;
    rsValidNext  = 1'b0;
    lsbValidNext = 1'b0;
    robReadyNext = 1'b0;
    robValueNext = '0;
    rsOpNext     = ADD;
    val2Next     = ops.val2;
    hasDep2Next  = ops.hasDep2;
    case (instr.r.opcode)
      LUI, AUIPC, JAL: begin // Complete at issue
        robValidNext = rdNonZero;
        rfValidNext  = rdNonZero;
        robReadyNext = 1'b1;
        if (instr.r.opcode == LUI) begin
          robValueNext = uImm;
        end else if (instr.r.opcode == AUIPC) begin
          robValueNext = stage.instrAddr + uImm;
        end else begin
          robValueNext = stage.instrAddr + `XLEN'(`INSTR_BYTES); // Link
        end
      end
      OP: begin
        robValidNext = 1'b1;
        rfValidNext  = rdNonZero;
        rsValidNext  = 1'b1;
        rsOpNext     = aluOp(instr.r.funct3, instr.r.funct7[5], instr.r.funct7[5]);
      end
      OPIMM: begin
        robValidNext = 1'b1;
        rfValidNext  = rdNonZero;
        rsValidNext  = 1'b1;
        hasDep2Next  = 1'b0;
        rsOpNext     = aluOp(instr.i.funct3, 1'b0, instr.r.funct7[5]);
        case (instr.i.funct3)
          3'b001, 3'b101: val2Next = {{(`XLEN-5){1'b0}}, instr.i.imm[4:0]}; // Shamt
          3'b011:         val2Next = {{(`XLEN-12){1'b0}}, instr.i.imm};     // SLTIU
          default:        val2Next = iImm;
        endcase
      end
      LOAD: begin
        robValidNext = 1'b1;
        rfValidNext  = 1'b1;
        lsbValidNext = 1'b1;
      end
      STORE: begin
        robValidNext = 1'b1;
        lsbValidNext = 1'b1;
      end
      default: begin
      end
    endcase
  end

  always_ff @(posedge clockIn) begin
    if (resetIn) begin
      robAddValid   <= 1'b0;
      rfUpdateValid <= 1'b0;
      rsAddValid    <= 1'b0;
      lsbAddValid   <= 1'b0;
    end else begin
      robAddValid   <= stage.instrValid && robValidNext;
      rfUpdateValid <= stage.instrValid && rfValidNext;
      rsAddValid    <= stage.instrValid && rsValidNext;
      lsbAddValid   <= stage.instrValid && lsbValidNext;
    end
  end

  // Issue payload, qualified by the valids above
  always_ff @(posedge clockIn) begin
    robAddType      <= isStore ? MEMWRITE : REGWRITE;
    robAddReady     <= robReadyNext;
    robAddValue     <= robValueNext;
    robAddDest      <= instr.r.rd;
    rfUpdateDest    <= instr.r.rd;
    rfUpdateIndex   <= robNext;
    rsAddOp         <= rsOpNext;
    rsAddRobIndex   <= robNext;
    rsAddVal1       <= ops.val1;
    rsAddHasDep1    <= ops.hasDep1;
    rsAddConstrt1   <= ops.dep1;
    rsAddVal2       <= val2Next;
    rsAddHasDep2    <= hasDep2Next;
    rsAddConstrt2   <= ops.dep2;
    lsbAddReadWrite <= !isStore; // High for a read
    lsbAddRobId     <= robNext;
    lsbAddHasDep    <= ops.hasDep1;
    lsbAddBase      <= ops.val1;
    lsbAddConstrtId <= ops.dep1;
    lsbAddOffset    <= isStore ? sImm : iImm;
    lsbAddTarget    <= instr.s.rs2;
    lsbAddOp        <= sizeOp(instr.i.funct3);
  end

endmodule

`default_nettype wire

/* issueInterfaces.sv */
`timescale 1ns/1ps
`default_nettype none
`include "issueUnit_defines.svh"

// Fetch to decode handoff, plus PC control
interface stageIf;
  logic               instrValid;  // One strobe per accepted word
  issuePkg::rvInstr_u instr;
  logic [`XLEN-1:0]   instrAddr;
  logic [`XLEN-1:0]   pc;
  logic               advance;     // Accepted a non-JAL word
  logic               jumpTaken;
  logic [`XLEN-1:0]   jumpTarget;

  modport fetch (output instrValid, instr, instrAddr, advance, input pc, jumpTaken);
  modport decode (input instrValid, instr, instrAddr, output jumpTaken, jumpTarget);
  modport counter (input advance, jumpTaken, jumpTarget, output pc);
endinterface

interface operandIf;
  logic [`XLEN-1:0]      val1;
  logic                  hasDep1;
  logic [`ROB_WIDTH-1:0] dep1;     // Register file tag
  logic [`XLEN-1:0]      val2;
  logic                  hasDep2;
  logic [`ROB_WIDTH-1:0] dep2;

  modport resolver (output val1, hasDep1, dep1, val2, hasDep2, dep2);
  modport decoder (input val1, hasDep1, dep1, val2, hasDep2, dep2);
endinterface

`default_nettype wire

/* issuePkg.sv */
`default_nettype none
`include "issueUnit_defines.svh"

package issuePkg;

  typedef enum logic [6:0] {
    LUI   = 7'b0110111,
    AUIPC = 7'b0010111,
    JAL   = 7'b1101111,
    LOAD  = 7'b0000011,
    STORE = 7'b0100011,
    OPIMM = 7'b0010011,
    OP    = 7'b0110011
  } opcode_e;

  typedef enum logic [3:0] {
    ADD  = 4'd0,
    SUB  = 4'd1,
    XOR  = 4'd2,
    OR   = 4'd3,
    AND  = 4'd4,
    SLL  = 4'd5,
    SRL  = 4'd6,
    SRA  = 4'd7,
    SLT  = 4'd10,
    SLTU = 4'd11
  } rsOp_e;

  typedef enum logic [2:0] {
    BYTE  = 3'd0,
    HALF  = 3'd1,
    WORD  = 3'd2,
    BYTEU = 3'd3,
    HALFU = 3'd4
  } lsbOp_e;

  typedef enum logic [1:0] {
    REGWRITE = 2'd0,
    MEMWRITE = 2'd2
  } robType_e;

  typedef struct packed {
    logic [6:0]                 funct7;
    logic [`REG_ADDR_WIDTH-1:0] rs2;
    logic [`REG_ADDR_WIDTH-1:0] rs1;
    logic [2:0]                 funct3;
    logic [`REG_ADDR_WIDTH-1:0] rd;
    opcode_e                    opcode;
  } rView_s;

  typedef struct packed {
    logic [11:0]                imm;
    logic [`REG_ADDR_WIDTH-1:0] rs1;
    logic [2:0]                 funct3;
    logic [`REG_ADDR_WIDTH-1:0] rd;
    opcode_e                    opcode;
  } iView_s;

  typedef struct packed {
    logic [6:0]                 immHi;
    logic [`REG_ADDR_WIDTH-1:0] rs2;
    logic [`REG_ADDR_WIDTH-1:0] rs1;
    logic [2:0]                 funct3;
    logic [4:0]                 immLo;
    opcode_e                    opcode;
  } sView_s;

  typedef struct packed {
    logic [19:0]                imm;
    logic [`REG_ADDR_WIDTH-1:0] rd;
    opcode_e                    opcode;
  } uView_s;

  typedef struct packed {
    logic                       imm20;
    logic [9:0]                 imm10to1;
    logic                       imm11;
    logic [7:0]                 imm19to12;
    logic [`REG_ADDR_WIDTH-1:0] rd;
    opcode_e                    opcode;
  } jView_s;

  // One instruction word seen through each format
  typedef union packed {
    rView_s r;
    iView_s i;
    sView_s s;
    uView_s u;
    jView_s j;
  } rvInstr_u;

endpackage

`default_nettype wire

/* issueUnit_defines.svh */
`ifndef ISSUE_UNIT_DEFINES_SVH
`define ISSUE_UNIT_DEFINES_SVH

`define XLEN           32            // Data and address width
`define ROB_WIDTH      4             // Reorder buffer index
`define REG_ADDR_WIDTH 5             // Register number
`define INSTR_BYTES    4             // PC step per word
`define RESET_PC       32'h0000_0000

`endif

/* list.f */
+incdir+.
issuePkg.sv
issueInterfaces.sv
fetchControl.sv
programCounter.sv
operandResolver.sv
issueDecoder.sv
instructionUnit.sv
tbClock.sv
instructionUnitTb.sv

/* operandResolver.sv */
`timescale 1ns/1ps
`default_nettype none
`include "issueUnit_defines.svh"

module operandResolver (
  input  wire                  rs1Dirty,
  input  wire [`ROB_WIDTH-1:0] rs1Dependency,
  input  wire [`XLEN-1:0]      rs1Value,
  input  wire                  rs2Dirty,
  input  wire [`ROB_WIDTH-1:0] rs2Dependency,
  input  wire [`XLEN-1:0]      rs2Value,
  input  wire                  rsUpdate,
  input  wire [`ROB_WIDTH-1:0] rsRobIndex,
  input  wire [`XLEN-1:0]      rsUpdateVal,
  input  wire                  lsbUpdate,
  input  wire [`ROB_WIDTH-1:0] lsbRobIndex,
  input  wire [`XLEN-1:0]      lsbUpdateVal,
  operandIf.resolver           ops
);

  logic rs1RsHit;
  logic rs1LsbHit;
  logic rs2RsHit;
  logic rs2LsbHit;

  // Same-cycle broadcasts that carry the pending tag
  assign rs1RsHit  = rs1Dirty && rsUpdate && rs1Dependency == rsRobIndex;
  assign rs1LsbHit = rs1Dirty && lsbUpdate && rs1Dependency == lsbRobIndex;
  assign rs2RsHit  = rs2Dirty && rsUpdate && rs2Dependency == rsRobIndex;
  assign rs2LsbHit = rs2Dirty && lsbUpdate && rs2Dependency == lsbRobIndex;

  assign ops.val1 = !rs1Dirty ? rs1Value :
                    rs1RsHit  ? rsUpdateVal :
                    rs1LsbHit ? lsbUpdateVal : '0;
  assign ops.hasDep1 = rs1Dirty && !rs1RsHit && !rs1LsbHit;
  assign ops.dep1    = rs1Dependency;

  assign ops.val2 = !rs2Dirty ? rs2Value :
                    rs2RsHit  ? rsUpdateVal :
                    rs2LsbHit ? lsbUpdateVal : '0;
  assign ops.hasDep2 = rs2Dirty && !rs2RsHit && !rs2LsbHit;
  assign ops.dep2    = rs2Dependency;

endmodule

`default_nettype wire

/* programCounter.sv */
`timescale 1ns/1ps
`default_nettype none
`include "issueUnit_defines.svh"

module programCounter (
  input  wire              clockIn,
  input  wire              resetIn,
  stageIf.counter          stage,
  output logic [`XLEN-1:0] pc
);

  logic [`XLEN-1:0] pcReg;

  always_ff @(posedge clockIn) begin
    if (resetIn) begin
      pcReg <= `RESET_PC;
    end else if (stage.jumpTaken) begin
      pcReg <= stage.jumpTarget; // JAL redirect from decode
    end else if (stage.advance) begin
      pcReg <= pcReg + `XLEN'(`INSTR_BYTES);
    end
  end

  assign pc       = pcReg;
  assign stage.pc = pcReg;

endmodule

`default_nettype wire

/* tbClock.sv */
`timescale 1ns/1ps
`default_nettype none

module tbClock (
  output logic clock,
  output logic reset
);

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock; // 100 ns period
  end

  initial begin
    reset = 1'b1;
    repeat (3) @(posedge clock);
    reset <= 1'b0; // Seen high at three rising edges
  end

endmodule

`default_nettype wire
